// File: bench/cpu_props.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_props (
	input logic clk,
	input logic arst_n,
	input logic wb_valid,
	input logic halted,
	input logic mem_write
);

	int unsigned wb_fails = 0;
	int unsigned halt_fails = 0;
	int unsigned store_fails = 0;

	// every retire takes at least fetch, decode and execute.
	wb_single: assert property (@(posedge clk) disable iff (!arst_n) wb_valid |=> !wb_valid)
		else begin
			wb_fails++;
			$error("wb_valid high on two consecutive cycles");
		end

	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
		else begin
			halt_fails++;
			$error("halted fell without a reset");
		end

	// stores retire without a register write.
	store_no_wb: assert property (@(posedge clk) disable iff (!arst_n) !(mem_write && wb_valid))
		else begin
			store_fails++;
			$error("data memory write and wb_valid high together");
		end

endmodule

bind cpu_top cpu_props u_props (
	.clk(clk), .arst_n(arst_n), .wb_valid(wb_valid), .halted(halted),
	.mem_write(ctrl.mem_write)
);

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

	logic clk = 1'b0;
	logic arst_n, run, load_en, wb_valid, halted;
	logic [7:0] load_addr;
	logic [4:0] wb_reg;
	logic [cpu_pkg::data_w-1:0] load_data, wb_data;
	logic [31:0] prog [$];
	logic [4:0] exp_reg [$];
	logic [31:0] exp_data [$];
	logic [31:0] used_regs;
	int wb_count = 0;
	int checks = 0;
	int wb_errors = 0;
	int end_errors = 0;
	int cycles = 0;
	int limit;
	int total;

	always #5 clk = ~clk;

	cpu_top #(.imem_words(256), .dmem_words(256), .reset_pc(32'h0)) uut (
		.clk(clk), .arst_n(arst_n), .run(run), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.halted(halted)
	);

	function automatic logic [31:0] rr_instr(cpu_pkg::opcode_e op, logic [4:0] rt,
			logic [4:0] ra, logic [4:0] rb, logic [1:0] sv, logic [2:0] funct);
		return {op, rt, ra, rb, 1'b0, sv, 5'd0, funct};
	endfunction

	function automatic logic [31:0] ri_instr(cpu_pkg::opcode_e op, logic [4:0] rt,
			logic [4:0] ra, logic [14:0] imm);
		return {op, rt, ra, 1'b0, imm};
	endfunction

	function automatic logic [31:0] movi_instr(logic [4:0] rt, logic [19:0] imm);
		return {cpu_pkg::op_movi, rt, 1'b0, imm};
	endfunction

	// distinct registers within one group of instructions.
	function automatic logic [4:0] fresh_reg();
		logic [4:0] r;
		r = 5'($urandom);
		while (used_regs[r])
			r = 5'($urandom);
		used_regs[r] = 1'b1;
		return r;
	endfunction

	task automatic build_program();
		logic [4:0] base, idx, x, y;
		logic [19:0] v;
		int off;
		for (int i = 0; i < 16; i++)
			prog.push_back(movi_instr(5'($urandom), {i[0], 19'($urandom)}));
		for (int i = 0; i < 12; i++)
			prog.push_back(rr_instr(cpu_pkg::op_alu, 5'($urandom), 5'($urandom),
				5'($urandom), 2'd0, 3'(i % 6)));
		// top immediate bit alternates so both extensions see it set.
		for (int i = 0; i < 4; i++) begin
			prog.push_back(ri_instr(cpu_pkg::op_addi, 5'($urandom), 5'($urandom),
				{i[0], 14'($urandom)}));
			prog.push_back(ri_instr(cpu_pkg::op_ori, 5'($urandom), 5'($urandom),
				{~i[0], 14'($urandom)}));
			prog.push_back(ri_instr(cpu_pkg::op_slli, 5'($urandom), 5'($urandom),
				15'($urandom)));
			prog.push_back(movi_instr(5'($urandom), {~i[0], 19'($urandom)}));
		end
		// stores and loads cross the two addressing modes on one address.
		for (int i = 0; i < 4; i++) begin
			used_regs = '0;
			base = fresh_reg();
			idx = fresh_reg();
			x = fresh_reg();
			y = fresh_reg();
			v[1:0] = 2'($urandom);
			off = int'($urandom_range(14, 0)) - 7;
			prog.push_back(movi_instr(base, 20'($urandom_range(191, 64) * 4)));
			prog.push_back(movi_instr(idx, 20'(off * 4)));
			prog.push_back(movi_instr(x, 20'($urandom)));
			prog.push_back(movi_instr(y, 20'($urandom)));
			off = off << v[1:0];
			prog.push_back(ri_instr(cpu_pkg::op_sw, x, base, 15'(off)));
			prog.push_back(rr_instr(cpu_pkg::op_lwx, fresh_reg(), base, idx, v[1:0], 3'd0));
			prog.push_back(rr_instr(cpu_pkg::op_swx, y, base, idx, v[1:0], 3'd0));
			prog.push_back(ri_instr(cpu_pkg::op_lw, fresh_reg(), base, 15'(off)));
		end
		// beq taken, beq not taken, bne taken, bne not taken, then three that may be skipped.
		for (int i = 0; i < 8; i++) begin
			used_regs = '0;
			x = fresh_reg();
			y = fresh_reg();
			v = 20'($urandom);
			prog.push_back(movi_instr(x, v));
			prog.push_back(movi_instr(y, (i % 4 == 0 || i % 4 == 3) ? v : ~v));
			prog.push_back(ri_instr((i % 4 < 2) ? cpu_pkg::op_beq : cpu_pkg::op_bne, y, x,
				15'($urandom_range(4, 2))));
			for (int k = 0; k < 3; k++)
				prog.push_back(movi_instr(fresh_reg(), 20'($urandom)));
		end
		prog.push_back({cpu_pkg::op_halt, 26'd0});
		prog.push_back(movi_instr(5'd1, 20'h12345));
		prog.push_back(movi_instr(5'd2, 20'h54321));
	endtask

	// instruction-set interpreter that lists every register write in order.
	function automatic void run_reference();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] ins, a, b, t, addr, val;
		logic wr, done;
		int pc, steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = '0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && pc >= 0 && pc < prog.size() && steps < 4096) begin
			ins = prog[pc];
			a = regs[ins[20:16]];
			b = regs[ins[15:11]];
			t = regs[ins[25:21]];
			addr = (ins[31:26] == cpu_pkg::op_lwx || ins[31:26] == cpu_pkg::op_swx) ?
			       a + (b << ins[9:8]) : a + {{15{ins[14]}}, ins[14:0], 2'b00};
			wr = 1'b1;
			val = '0;
			pc++;
			steps++;
			case (cpu_pkg::opcode_e'(ins[31:26]))
				cpu_pkg::op_alu: begin
					case (cpu_pkg::alu_op_e'(ins[2:0]))
						cpu_pkg::alu_add: val = a + b;
						cpu_pkg::alu_sub: val = a - b;
						cpu_pkg::alu_and: val = a & b;
						cpu_pkg::alu_or:  val = a | b;
						cpu_pkg::alu_xor: val = a ^ b;
						cpu_pkg::alu_sll: val = a << b[4:0];
						default:          val = '0;
					endcase
				end
				cpu_pkg::op_addi: val = a + {{17{ins[14]}}, ins[14:0]};
				cpu_pkg::op_ori:  val = a | {17'd0, ins[14:0]};
				cpu_pkg::op_slli: val = a << ins[14:10];
				cpu_pkg::op_movi: val = {{12{ins[19]}}, ins[19:0]};
				cpu_pkg::op_lw, cpu_pkg::op_lwx: val = mem[addr[9:2]];
				cpu_pkg::op_sw, cpu_pkg::op_swx: begin
					mem[addr[9:2]] = t;
					wr = 1'b0;
				end
				cpu_pkg::op_beq, cpu_pkg::op_bne: begin
					wr = 1'b0;
					if ((a == t) == (ins[31:26] == cpu_pkg::op_beq))
						pc = pc - 1 + int'($signed(ins[14:0]));
				end
				default: begin
					wr = 1'b0;
					done = 1'b1;
				end
			endcase
			if (wr) begin
				regs[ins[25:21]] = val;
				exp_reg.push_back(ins[25:21]);
				exp_data.push_back(val);
			end
		end
	endfunction

	always @(negedge clk) begin
		if (arst_n && wb_valid) begin
			if (halted) begin
				wb_errors++;
				$display("register write seen after halt");
			end
			if (wb_count >= exp_reg.size()) begin
				wb_errors++;
				$display("more register writes than the reference predicts");
			end else begin
				checks++;
				if (wb_reg !== exp_reg[wb_count]) begin
					wb_errors++;
					$display("ERROR wb_reg: got 0x%h, expected 0x%h (write %0d)",
						wb_reg, exp_reg[wb_count], wb_count);
				end
				if (wb_data !== exp_data[wb_count]) begin
					wb_errors++;
					$display("ERROR wb_data: got 0x%h, expected 0x%h (write %0d)",
						wb_data, exp_data[wb_count], wb_count);
				end
			end
			wb_count++;
		end
	end

	initial begin
		void'($urandom(32'heb99b69e));
		arst_n = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_program();
		run_reference();
		limit = prog.size() * 5 + 40;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		foreach (prog[i]) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= 8'(i);
			load_data <= prog[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		run <= 1'b1;
		while (!halted && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!halted) begin
			end_errors++;
			$display("timeout: core did not halt within %0d cycles", limit);
		end
		// late writes after halt would show up here.
		repeat (20) @(posedge clk);
		if (wb_count != exp_reg.size()) begin
			end_errors++;
			$display("saw %0d register writes, reference predicts %0d", wb_count,
				exp_reg.size());
		end
		total = wb_errors + end_errors + int'(uut.u_props.wb_fails) +
		        int'(uut.u_props.halt_fails) + int'(uut.u_props.store_fails);
		$display("writes %0d of %0d, checks %0d, errors %0d", wb_count, exp_reg.size(),
			checks, total);
		if (total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_top.f
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/word_ram.sv
logic/operand_muxs.sv
logic/cpu_controller.sv
logic/cpu_top.sv
bench/cpu_props.sv
bench/cpu_tb.sv

// File: logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  logic [cpu_pkg::data_w-1:0] a,
	input  logic [cpu_pkg::data_w-1:0] b,
	input  cpu_pkg::alu_op_e           op,
	output logic [cpu_pkg::data_w-1:0] result,
	output logic                       eq
);

	always_comb begin
		case (op)
			cpu_pkg::alu_add: result = a + b;
			cpu_pkg::alu_sub: result = a - b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_or:  result = a | b;
			cpu_pkg::alu_xor: result = a ^ b;
			// shift amount is the low five bits only.
			cpu_pkg::alu_sll: result = a << b[4:0];
			default:          result = '0;
		endcase
	end

	// branch compare, independent of op.
	assign eq = (a == b);

endmodule

`default_nettype wire

// File: logic/cpu_controller.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_controller (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              run,
	input  cpu_pkg::opcode_e  opcode,
	input  logic [2:0]        funct,
	input  logic              alu_eq,
	output cpu_pkg::ctrl_t    ctrl,
	output logic              wb_valid,
	output logic              halted
);

	typedef enum logic [2:0] {
		s_idle,
		s_fetch,
		s_decode,
		s_execute,
		s_memory,
		s_writeback
	} state_e;

	state_e state, state_nxt;
	logic is_load, is_store, is_write;

	assign is_load   = (opcode == cpu_pkg::op_lw) || (opcode == cpu_pkg::op_lwx);
	assign is_store  = (opcode == cpu_pkg::op_sw) || (opcode == cpu_pkg::op_swx);
	assign is_write  = (opcode == cpu_pkg::op_alu) || (opcode == cpu_pkg::op_addi) ||
	                   (opcode == cpu_pkg::op_ori) || (opcode == cpu_pkg::op_slli) ||
	                   (opcode == cpu_pkg::op_movi);

	always_comb begin
		state_nxt = state;
		case (state)
			s_idle: begin
				if (run && !halted)
					state_nxt = s_fetch;
			end
			s_fetch:  state_nxt = s_decode;
			s_decode: state_nxt = s_execute;
			s_execute: begin
				if (opcode == cpu_pkg::op_halt)
					state_nxt = s_idle;
				else if (is_load || is_store)
					state_nxt = s_memory;
				else if (is_write)
					state_nxt = s_writeback;
				else
					state_nxt = run ? s_fetch : s_idle;
			end
			s_memory: begin
				if (is_load)
					state_nxt = s_writeback;
				else
					state_nxt = run ? s_fetch : s_idle;
			end
			s_writeback: state_nxt = run ? s_fetch : s_idle;
			default: state_nxt = s_idle;
		endcase
	end

	// selects follow the opcode, enables follow the state.
	always_comb begin
		ctrl = '0;
		ctrl.alu_op   = cpu_pkg::alu_add;
		ctrl.imm_sel  = cpu_pkg::imm_se15;
		ctrl.src2_sel = cpu_pkg::src2_rb;
		ctrl.wb_sel   = cpu_pkg::wb_alu;
		case (opcode)
			cpu_pkg::op_alu:  ctrl.alu_op = cpu_pkg::alu_op_e'(funct);
			cpu_pkg::op_addi: ctrl.src2_sel = cpu_pkg::src2_imm;
			cpu_pkg::op_ori: begin
				ctrl.alu_op   = cpu_pkg::alu_or;
				ctrl.imm_sel  = cpu_pkg::imm_ze15;
				ctrl.src2_sel = cpu_pkg::src2_imm;
			end
			cpu_pkg::op_slli: begin
				ctrl.alu_op   = cpu_pkg::alu_sll;
				ctrl.imm_sel  = cpu_pkg::imm_ze5;
				ctrl.src2_sel = cpu_pkg::src2_imm;
			end
			cpu_pkg::op_movi: begin
				ctrl.imm_sel = cpu_pkg::imm_se20;
				ctrl.wb_sel  = cpu_pkg::wb_imm;
			end
			cpu_pkg::op_lw, cpu_pkg::op_sw: ctrl.src2_sel = cpu_pkg::src2_ls_imm;
			cpu_pkg::op_lwx, cpu_pkg::op_swx: ctrl.src2_sel = cpu_pkg::src2_rb_sv;
			cpu_pkg::op_beq, cpu_pkg::op_bne: begin
				ctrl.alu_op   = cpu_pkg::alu_sub;
				ctrl.src2_sel = cpu_pkg::src2_rt;
			end
			default: ;
		endcase
		if (is_load)
			ctrl.wb_sel = cpu_pkg::wb_mem;

		ctrl.ir_load   = (state == s_decode);
		ctrl.pc_write  = (state == s_execute) && (opcode != cpu_pkg::op_halt);
		ctrl.mem_write = (state == s_memory) && is_store;
		ctrl.reg_write = (state == s_writeback);
		ctrl.branch_take = (state == s_execute) &&
		                   (((opcode == cpu_pkg::op_beq) && alu_eq) ||
		                    ((opcode == cpu_pkg::op_bne) && !alu_eq));
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= s_idle;
			wb_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			state    <= state_nxt;
			wb_valid <= (state == s_writeback);
			if ((state == s_execute) && (opcode == cpu_pkg::op_halt))
				halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int data_w = 32;

	// instruction classes.
	typedef enum logic [5:0] {
		op_alu  = 6'h00,
		op_movi = 6'h02,
		op_addi = 6'h08,
		op_ori  = 6'h0d,
		op_slli = 6'h10,
		op_lw   = 6'h20,
		op_lwx  = 6'h21,
		op_sw   = 6'h28,
		op_swx  = 6'h29,
		op_beq  = 6'h30,
		op_bne  = 6'h31,
		op_halt = 6'h3f
	} opcode_e;

	// register ops carry this code in funct.
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_sll = 3'd5
	} alu_op_e;

	typedef enum logic [1:0] {
		imm_ze5  = 2'd0,
		imm_se15 = 2'd1,
		imm_ze15 = 2'd2,
		imm_se20 = 2'd3
	} imm_sel_e;

	typedef enum logic [2:0] {
		src2_rb     = 3'd0,
		src2_imm    = 3'd1,
		src2_ls_imm = 3'd2,
		src2_rb_sv  = 3'd3,
		src2_rt     = 3'd4
	} src2_sel_e;

	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_imm = 2'd1,
		wb_mem = 2'd2
	} wb_sel_e;

	// imm5 is [14:10], imm15 is [14:0] and imm20 is [19:0] of the same word.
	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic       rsvd_10;
		logic [1:0] sv;
		logic [4:0] rsvd_7_3;
		logic [2:0] funct;
	} instr_t;

	typedef struct packed {
		alu_op_e   alu_op;
		imm_sel_e  imm_sel;
		src2_sel_e src2_sel;
		wb_sel_e   wb_sel;
		logic      reg_write;
		logic      mem_write;
		logic      pc_write;
		logic      branch_take;
		logic      ir_load;
	} ctrl_t;

endpackage

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
	parameter int                         imem_words = 256,
	parameter int                         dmem_words = 256,
	parameter logic [cpu_pkg::data_w-1:0] reset_pc   = '0
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       run,
	input  logic                       load_en,
	input  logic [7:0]                 load_addr,
	input  logic [cpu_pkg::data_w-1:0] load_data,
	output logic                       wb_valid,
	output logic [4:0]                 wb_reg,
	output logic [cpu_pkg::data_w-1:0] wb_data,
	output logic                       halted
);

	localparam int w = cpu_pkg::data_w;
	localparam int imem_aw = $clog2(imem_words);
	localparam int dmem_aw = $clog2(dmem_words);

	cpu_pkg::instr_t ir_q;
	cpu_pkg::ctrl_t  ctrl;
	logic [w-1:0] pc_q, imm_q, alu_q, branch_target;
	logic [w-1:0] ra_data, rb_data, rt_data;
	logic [w-1:0] imm_ext, alu_src2, alu_result, write_reg_data;
	logic [w-1:0] imem_rdata, dmem_rdata;
	logic [imem_aw-1:0] imem_addr;
	logic loading, alu_eq;

	// loader owns the instruction memory only while the core is stopped.
	assign loading   = load_en && !run;
	assign imem_addr = loading ? imem_aw'(load_addr) : pc_q[imem_aw+1:2];

	assign branch_target = pc_q + {{(w-17){ir_q[14]}}, ir_q[14:0], 2'b00};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc_q <= reset_pc;
		else if (ctrl.pc_write)
			pc_q <= ctrl.branch_take ? branch_target : pc_q + w'(4);
	end

	// operands hold steady from execute through writeback.
	always_ff @(posedge clk) begin
		if (ctrl.ir_load)
			ir_q <= cpu_pkg::instr_t'(imem_rdata);
		imm_q <= imm_ext;
		alu_q <= alu_result;
		if (ctrl.reg_write) begin
			wb_reg  <= ir_q.rt;
			wb_data <= write_reg_data;
		end
	end

	cpu_controller u_ctrl (
		.clk(clk), .arst_n(arst_n), .run(run), .opcode(ir_q.opcode), .funct(ir_q.funct),
		.alu_eq(alu_eq), .ctrl(ctrl), .wb_valid(wb_valid), .halted(halted)
	);

	operand_muxs u_muxs (
		.imm5(ir_q[14:10]), .imm15(ir_q[14:0]), .imm20(ir_q[19:0]), .sv(ir_q.sv),
		.rb_data(rb_data), .rt_data(rt_data), .alu_result(alu_q), .r_imm_extend(imm_q),
		.mem_read_data(dmem_rdata), .imm_sel(ctrl.imm_sel), .src2_sel(ctrl.src2_sel),
		.wb_sel(ctrl.wb_sel), .imm_extend(imm_ext), .alu_src2(alu_src2),
		.write_reg_data(write_reg_data)
	);

	reg_file u_regs (
		.clk(clk), .arst_n(arst_n), .ra_addr(ir_q.ra), .rb_addr(ir_q.rb), .rt_addr(ir_q.rt),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data), .write_en(ctrl.reg_write),
		.write_addr(ir_q.rt), .write_data(write_reg_data)
	);

	alu u_alu (
		.a(ra_data), .b(alu_src2), .op(ctrl.alu_op), .result(alu_result), .eq(alu_eq)
	);

	word_ram #(.words(imem_words)) u_imem (
		.clk(clk), .addr(imem_addr), .write_en(loading), .write_data(load_data),
		.read_data(imem_rdata)
	);

	// byte address of an aligned word.
	word_ram #(.words(dmem_words)) u_dmem (
		.clk(clk), .addr(alu_q[dmem_aw+1:2]), .write_en(ctrl.mem_write),
		.write_data(rt_data), .read_data(dmem_rdata)
	);

endmodule

`default_nettype wire

// File: logic/operand_muxs.sv
`timescale 1ns/10ps
`default_nettype none

module operand_muxs (
	input  logic [4:0]                 imm5,
	input  logic [14:0]                imm15,
	input  logic [19:0]                imm20,
	input  logic [1:0]                 sv,
	input  logic [cpu_pkg::data_w-1:0] rb_data,
	input  logic [cpu_pkg::data_w-1:0] rt_data,
	input  logic [cpu_pkg::data_w-1:0] alu_result,
	input  logic [cpu_pkg::data_w-1:0] r_imm_extend,
	input  logic [cpu_pkg::data_w-1:0] mem_read_data,
	input  cpu_pkg::imm_sel_e          imm_sel,
	input  cpu_pkg::src2_sel_e         src2_sel,
	input  cpu_pkg::wb_sel_e           wb_sel,
	output logic [cpu_pkg::data_w-1:0] imm_extend,
	output logic [cpu_pkg::data_w-1:0] alu_src2,
	output logic [cpu_pkg::data_w-1:0] write_reg_data
);

	localparam int w = cpu_pkg::data_w;

	always_comb begin
		case (imm_sel)
			cpu_pkg::imm_ze5:  imm_extend = {{(w-5){1'b0}}, imm5};
			cpu_pkg::imm_se15: imm_extend = {{(w-15){imm15[14]}}, imm15};
			cpu_pkg::imm_ze15: imm_extend = {{(w-15){1'b0}}, imm15};
			cpu_pkg::imm_se20: imm_extend = {{(w-20){imm20[19]}}, imm20};
			default:           imm_extend = '0;
		endcase
	end

	always_comb begin
		case (src2_sel)
			cpu_pkg::src2_rb:  alu_src2 = rb_data;
			cpu_pkg::src2_imm: alu_src2 = imm_extend;
			// word offset turned into a byte offset.
			cpu_pkg::src2_ls_imm: alu_src2 = {{(w-17){imm15[14]}}, imm15, 2'b00};
			cpu_pkg::src2_rb_sv:  alu_src2 = rb_data << sv;
			cpu_pkg::src2_rt:     alu_src2 = rt_data;
			default:              alu_src2 = '0;
		endcase
	end

	always_comb begin
		case (wb_sel)
			cpu_pkg::wb_alu: write_reg_data = alu_result;
			cpu_pkg::wb_imm: write_reg_data = r_imm_extend;
			cpu_pkg::wb_mem: write_reg_data = mem_read_data;
			default:         write_reg_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [4:0]                 ra_addr,
	input  logic [4:0]                 rb_addr,
	input  logic [4:0]                 rt_addr,
	output logic [cpu_pkg::data_w-1:0] ra_data,
	output logic [cpu_pkg::data_w-1:0] rb_data,
	output logic [cpu_pkg::data_w-1:0] rt_data,
	input  logic                       write_en,
	input  logic [4:0]                 write_addr,
	input  logic [cpu_pkg::data_w-1:0] write_data
);

	logic [cpu_pkg::data_w-1:0] regs [32];

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/word_ram.sv
`timescale 1ns/10ps
`default_nettype none

module word_ram #(
	parameter int words = 256
) (
	input  logic                       clk,
	input  logic [$clog2(words)-1:0]   addr,
	input  logic                       write_en,
	input  logic [cpu_pkg::data_w-1:0] write_data,
	output logic [cpu_pkg::data_w-1:0] read_data
);

	logic [cpu_pkg::data_w-1:0] mem [words];

	// contents start cleared.
	initial begin
		for (int i = 0; i < words; i++)
			mem[i] = '0;
	end

	// write-first, so a write shows on the read port next cycle.
	always_ff @(posedge clk) begin
		if (write_en) begin
			mem[addr] <= write_data;
			read_data <= write_data;
		end else begin
			read_data <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f cpu_top.f -o cpu_sim || exit 1
out=$(./obj_dir/cpu_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
